/* sim.f */
+incdir+include
verilog/hazard_pkg.sv
verilog/regMatch.sv
verilog/hazard.sv
verilog/ctrlPipe.sv
verilog/hazardTop.sv
testbench/tbClock.sv
testbench/hazardTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the hazard subsystem testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module hazardTb -f sim.f -o simv > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* testbench/hazardTb.sv */
`timescale 1ns/1ns
`include "hazard_settings.svh"

module hazardTb;

  localparam int periodNs       = 8;
  localparam int resetCycles    = 3;
  localparam int directedCycles = 160;
  localparam int randomCycles   = 200;
  // Twice the full sequence plus a short drain
  localparam int watchdogNs     = 2 * periodNs *
                                  (resetCycles + directedCycles + randomCycles + 8);

  // External strobes of the hazard unit driven as one bundle
  typedef struct packed {
    logic                       branchTakenE;
    logic                       pcWrPendingF;
    logic                       pcSrcW;
    hazard_pkg::exceptionFlushT exceptionFlush;
    logic                       exceptionStallD;
    logic                       dStall;
    logic                       iStall;
    logic                       coProcEn;
    logic                       uOpStallD;
    logic                       ldmStmForwardE;
    logic                       regToCpsr;
    logic                       cpsrToReg;
  } strobeT;

  localparam strobeT              noStrobes = '0;
  localparam hazard_pkg::stageOpT emptyOp   = '0;

  logic                   clk;
  logic                   arstN;
  hazard_pkg::stageOpT    opF;
  strobeT                 strb;
  hazard_pkg::forwardSelT forwardAE;
  hazard_pkg::forwardSelT forwardBE;
  hazard_pkg::pipeCtrlT   ctrl;
  logic                   incrementE;
  logic                   stallUop;
  hazard_pkg::stageOpT    opW;

  // Reference model state with one tag per stage
  hazard_pkg::stageOpT    mD;
  hazard_pkg::stageOpT    mE;
  hazard_pkg::stageOpT    mM;
  hazard_pkg::stageOpT    mW;
  // Model results
  logic                   aFromM;
  logic                   aFromW;
  logic                   bFromM;
  logic                   bFromW;
  logic                   loadUse;
  logic                   cacheStall;
  logic                   ctrlWrite;
  hazard_pkg::forwardSelT expFwdA;
  hazard_pkg::forwardSelT expFwdB;
  hazard_pkg::pipeCtrlT   expCtrl;

  // Scenario reach counters
  int fwdMemSeen = 0;
  int fwdWbSeen = 0;
  int loadUseSeen = 0;
  int cacheStallSeen = 0;

  tbClock #(.periodNs(periodNs), .resetCycles(resetCycles)) uClock
  (
    .clk   (clk),
    .arstN (arstN)
  );

  hazardTop uut
  (
    .clk             (clk),
    .arstN           (arstN),
    .opF             (opF),
    .branchTakenE    (strb.branchTakenE),
    .pcWrPendingF    (strb.pcWrPendingF),
    .pcSrcW          (strb.pcSrcW),
    .exceptionFlush  (strb.exceptionFlush),
    .exceptionStallD (strb.exceptionStallD),
    .dStall          (strb.dStall),
    .iStall          (strb.iStall),
    .coProcEn        (strb.coProcEn),
    .uOpStallD       (strb.uOpStallD),
    .ldmStmForwardE  (strb.ldmStmForwardE),
    .regToCpsr       (strb.regToCpsr),
    .cpsrToReg       (strb.cpsrToReg),
    .forwardAE       (forwardAE),
    .forwardBE       (forwardBE),
    .ctrl            (ctrl),
    .incrementE      (incrementE),
    .stallUop        (stallUop),
    .opW             (opW)
  );

  // Expected hazard outputs from the model tags and the current strobes
  always_comb
  begin
    // A live E operand meets a writing M or W destination
    aFromM = mE.valid && mE.useA && (mE.srcA == mM.dest) && mM.regWrite;
    aFromW = mE.valid && mE.useA && (mE.srcA == mW.dest) && mW.regWrite;
    bFromM = mE.valid && mE.useB && (mE.srcB == mM.dest) && mM.regWrite;
    bFromW = mE.valid && mE.useB && (mE.srcB == mW.dest) && mW.regWrite;
    // Load in E whose result a D operand needs
    loadUse = mE.memToReg && mD.valid &&
              ((mD.useA && (mD.srcA == mE.dest)) || (mD.useB && (mD.srcB == mE.dest)));
    cacheStall = strb.dStall || strb.iStall;
    ctrlWrite  = strb.regToCpsr || strb.cpsrToReg || strb.coProcEn;
    expFwdA = (aFromM || strb.ldmStmForwardE) ? 2'd2 : (aFromW ? 2'd1 : 2'd0);
    expFwdB = bFromM ? 2'd2 : (bFromW ? 2'd1 : 2'd0);
    expCtrl.stallF = loadUse || strb.pcWrPendingF || cacheStall || strb.uOpStallD ||
                     ctrlWrite;
    expCtrl.stallD = loadUse || cacheStall || strb.uOpStallD || strb.exceptionStallD;
    expCtrl.stallE = cacheStall;
    expCtrl.stallM = cacheStall;
    expCtrl.stallW = cacheStall;
    expCtrl.flushD = strb.pcWrPendingF || strb.pcSrcW || strb.branchTakenE || strb.iStall ||
                     ctrlWrite || strb.exceptionFlush.flushD;
    expCtrl.flushE = loadUse || strb.branchTakenE || strb.exceptionFlush.flushE;
    expCtrl.flushM = strb.exceptionFlush.flushM;
    expCtrl.flushW = cacheStall || strb.exceptionFlush.flushW;
  end

  // Model tag registers hold on stall, take a bubble on flush and otherwise advance
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      mD <= emptyOp;
      mE <= emptyOp;
      mM <= emptyOp;
      mW <= emptyOp;
    end
    else
    begin
      if (!expCtrl.stallD)
        mD <= expCtrl.flushD ? emptyOp : opF;
      if (!expCtrl.stallE)
        mE <= expCtrl.flushE ? emptyOp : mD;
      if (!expCtrl.stallM)
        mM <= expCtrl.flushM ? emptyOp : mE;
      // Writeback flush beats its stall
      if (expCtrl.flushW)
        mW <= emptyOp;
      else if (!expCtrl.stallW)
        mW <= mM;
    end
  end

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("ERROR at %0t ns: %s is %h, model expects %h", $time, name, got, want);
    $display("Test failed");
    $fatal(1, "Output mismatch against the reference model");
  endtask

  // Outputs sampled on the falling edge half a cycle after the inputs settle
  assert property (@(negedge clk) disable iff (!arstN) forwardAE == expFwdA)
    else reportMismatch("forwardAE", 32'(forwardAE), 32'(expFwdA));
  assert property (@(negedge clk) disable iff (!arstN) forwardBE == expFwdB)
    else reportMismatch("forwardBE", 32'(forwardBE), 32'(expFwdB));
  assert property (@(negedge clk) disable iff (!arstN) ctrl == expCtrl)
    else reportMismatch("ctrl", 32'(ctrl), 32'(expCtrl));
  assert property (@(negedge clk) disable iff (!arstN) incrementE == strb.ldmStmForwardE)
    else reportMismatch("incrementE", 32'(incrementE), 32'(strb.ldmStmForwardE));
  assert property (@(negedge clk) disable iff (!arstN) stallUop == (loadUse || cacheStall))
    else reportMismatch("stallUop", 32'(stallUop), 32'(loadUse || cacheStall));
  assert property (@(negedge clk) disable iff (!arstN) opW == mW)
    else reportMismatch("opW", 32'(opW), 32'(mW));

  // Count the hazard cases the stimulus actually produced
  always @(negedge clk)
  begin
    if (arstN)
    begin
      if (aFromM)
        fwdMemSeen = fwdMemSeen + 1;
      if (expFwdA == 2'd1)
        fwdWbSeen = fwdWbSeen + 1;
      if (loadUse)
        loadUseSeen = loadUseSeen + 1;
      if (cacheStall)
        cacheStallSeen = cacheStallSeen + 1;
    end
  end

  // Valid tag with the given register fields
  function automatic hazard_pkg::stageOpT makeOp(input logic useA, input int srcA,
                                                 input logic useB, input int srcB,
                                                 input int dest, input logic regWrite,
                                                 input logic memToReg);
    hazard_pkg::stageOpT op;
    op.valid    = 1'b1;
    op.useA     = useA;
    op.useB     = useB;
    op.srcA     = hazard_pkg::regAddrT'(srcA);
    op.srcB     = hazard_pkg::regAddrT'(srcB);
    op.dest     = hazard_pkg::regAddrT'(dest);
    op.regWrite = regWrite;
    op.memToReg = memToReg;
    return op;
  endfunction

  // Mostly valid tags where an invalid one is a plain bubble
  function automatic hazard_pkg::stageOpT randomOp();
    hazard_pkg::stageOpT op;
    op.valid    = ($urandom % 8) != 0;
    op.useA     = ($urandom % 2) == 1;
    op.useB     = ($urandom % 2) == 1;
    op.srcA     = hazard_pkg::regAddrT'($urandom % `REG_COUNT);
    op.srcB     = hazard_pkg::regAddrT'($urandom % `REG_COUNT);
    op.dest     = hazard_pkg::regAddrT'($urandom % `REG_COUNT);
    op.regWrite = ($urandom % 4) != 0;
    op.memToReg = op.regWrite && (($urandom % 4) == 0);
    if (!op.valid)
      op = emptyOp;
    return op;
  endfunction

  function automatic strobeT oneStrobe(input int which);
    logic [$bits(strobeT)-1:0] bits;
    bits = '0;
    bits[which] = 1'b1;
    return bits;
  endfunction

  // Each strobe set with probability 1/32
  function automatic strobeT sparseStrobes();
    logic [$bits(strobeT)-1:0] bits;
    for (int k = 0; k < $bits(strobeT); k++)
      bits[k] = ($urandom % 32) == 0;
    return bits;
  endfunction

  // One clock step where the fetch side keeps its tag if the last edge stalled F
  task automatic step(input hazard_pkg::stageOpT op, input strobeT s);
    logic fetchHeld;
    @(negedge clk);
    fetchHeld = ctrl.stallF;
    @(posedge clk);
    #1;
    strb = s;
    if (!fetchHeld)
      opF = op;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) step(emptyOp, noStrobes);
  endtask

  // Strobe held for n cycles over random traffic and followed by a quiet tail
  task automatic pulseStrobes(input strobeT s, input int n);
    repeat (n) step(randomOp(), s);
    repeat (4) step(randomOp(), noStrobes);
  endtask

  initial
  begin
    void'($urandom(32'hcc66_19e5));
    opF  = emptyOp;
    strb = noStrobes;
    @(posedge arstN);

    // Writers of r3 in both M and W while its reader is in E
    step(makeOp(1'b0, 0, 1'b0, 0, 3, 1'b1, 1'b0), noStrobes);
    step(makeOp(1'b0, 0, 1'b0, 0, 3, 1'b1, 1'b0), noStrobes);
    step(makeOp(1'b1, 3, 1'b1, 5, 8, 1'b1, 1'b0), noStrobes);
    idleCycles(4);
    // r6 only in W when its reader enters E
    step(makeOp(1'b0, 0, 1'b0, 0, 6, 1'b1, 1'b0), noStrobes);
    step(emptyOp, noStrobes);
    step(makeOp(1'b1, 6, 1'b1, 6, 9, 1'b0, 1'b0), noStrobes);
    idleCycles(4);
    // r7 produced without regWrite
    step(makeOp(1'b0, 0, 1'b0, 0, 7, 1'b0, 1'b0), noStrobes);
    step(makeOp(1'b1, 7, 1'b1, 7, 2, 1'b1, 1'b0), noStrobes);
    idleCycles(4);
    // Load of r4 directly followed by its user
    step(makeOp(1'b0, 0, 1'b0, 0, 4, 1'b1, 1'b1), noStrobes);
    step(makeOp(1'b1, 4, 1'b0, 0, 10, 1'b1, 1'b0), noStrobes);
    step(makeOp(1'b1, 1, 1'b1, 2, 11, 1'b1, 1'b0), noStrobes);
    idleCycles(6);

    // Every strobe alone over branches, PC and CPSR writes,
    // cache stalls, exception flushes, micro-op stalls and LDM/STM forwarding
    for (int k = 0; k < $bits(strobeT); k++)
      pulseStrobes(oneStrobe(k), 3);

    repeat (randomCycles) step(randomOp(), sparseStrobes());
    idleCycles(6);

    if (fwdMemSeen > 0 && fwdWbSeen > 0 && loadUseSeen > 0 && cacheStallSeen > 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("Some hazard cases were never produced by the stimulus");
      $display("Test failed");
      $fatal(1, "Incomplete stimulus");
    end
  end

  initial
  begin
    #(watchdogNs);
    $display("Watchdog expired before the test sequence finished");
    $display("Test failed");
    $fatal(1, "Simulation hang");
  end

endmodule

/* testbench/tbClock.sv */
`timescale 1ns/1ns

module tbClock
#(
  parameter int periodNs    = 8,
  parameter int resetCycles = 3
)
(
  output logic clk,
  output logic arstN
);

  // Free running clock, low at time zero
  initial
  begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset held over the first rising edges
  // Released 1 ns after an edge like every other input
  initial
  begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
  end

endmodule

/* verilog/hazardTop.sv */
`timescale 1ns/1ns

module hazardTop
(
  input  logic                       clk,
  input  logic                       arstN,
  // Incoming fetch tag
  input  hazard_pkg::stageOpT        opF,
  // External strobes, passed straight to hazard
  input  logic                       branchTakenE,
  input  logic                       pcWrPendingF,
  input  logic                       pcSrcW,
  input  hazard_pkg::exceptionFlushT exceptionFlush,
  input  logic                       exceptionStallD,
  input  logic                       dStall,
  input  logic                       iStall,
  input  logic                       coProcEn,
  input  logic                       uOpStallD,
  input  logic                       ldmStmForwardE,
  input  logic                       regToCpsr,
  input  logic                       cpsrToReg,
  // Hazard results
  output hazard_pkg::forwardSelT     forwardAE,
  output hazard_pkg::forwardSelT     forwardBE,
  output hazard_pkg::pipeCtrlT       ctrl,
  output logic                       incrementE,
  output logic                       stallUop,
  // Tag leaving the pipe
  output hazard_pkg::stageOpT        opW
);

  hazard_pkg::stageOpT opD;
  hazard_pkg::stageOpT opE;
  hazard_pkg::stageOpT opM;
  hazard_pkg::matchT   match;

  // Destination qualifiers for the hazard unit
  logic regWriteM;
  logic regWriteW;
  logic memToRegE;

  assign regWriteM = opM.regWrite;
  assign regWriteW = opW.regWrite;
  assign memToRegE = opE.memToReg;

  // Tag registers, steered by the hazard levels
  ctrlPipe uPipe
  (
    .clk   (clk),
    .arstN (arstN),
    .opF   (opF),
    .ctrl  (ctrl),
    .opD   (opD),
    .opE   (opE),
    .opM   (opM),
    .opW   (opW)
  );

  // Register comparators
  regMatch uMatch
  (
    .opD   (opD),
    .opE   (opE),
    .opM   (opM),
    .opW   (opW),
    .match (match)
  );

  // Forwarding, stall and flush
  hazard uHazard
  (
    .match           (match),
    .regWriteM       (regWriteM),
    .regWriteW       (regWriteW),
    .memToRegE       (memToRegE),
    .branchTakenE    (branchTakenE),
    .pcWrPendingF    (pcWrPendingF),
    .pcSrcW          (pcSrcW),
    .exceptionFlush  (exceptionFlush),
    .exceptionStallD (exceptionStallD),
    .dStall          (dStall),
    .iStall          (iStall),
    .coProcEn        (coProcEn),
    .uOpStallD       (uOpStallD),
    .ldmStmForwardE  (ldmStmForwardE),
    .regToCpsr       (regToCpsr),
    .cpsrToReg       (cpsrToReg),
    .forwardAE       (forwardAE),
    .forwardBE       (forwardBE),
    .ctrl            (ctrl),
    .incrementE      (incrementE),
    .stallUop        (stallUop)
  );

endmodule

/* verilog/ctrlPipe.sv */
`timescale 1ns/1ns

module ctrlPipe
(
  input  logic                 clk,
  input  logic                 arstN,
  // Tag of the instruction being fetched
  input  hazard_pkg::stageOpT  opF,
  // Stall and flush levels from hazard
  input  hazard_pkg::pipeCtrlT ctrl,
  // Registered stage tags
  output hazard_pkg::stageOpT  opD,
  output hazard_pkg::stageOpT  opE,
  output hazard_pkg::stageOpT  opM,
  output hazard_pkg::stageOpT  opW
);

  // Next-state values for the four tag registers
  hazard_pkg::stageOpT nextD;
  hazard_pkg::stageOpT nextE;
  hazard_pkg::stageOpT nextM;
  hazard_pkg::stageOpT nextW;

  // Common stage update
  // flushFirst picks which of stall or flush wins when both are set
  function automatic hazard_pkg::stageOpT stageNext
  (
    input logic                stall,
    input logic                flush,
    input logic                flushFirst,
    input hazard_pkg::stageOpT cur,
    input hazard_pkg::stageOpT prev
  );
    hazard_pkg::stageOpT result;
    if (flushFirst && flush)
      result = hazard_pkg::bubbleOp;
    else if (stall)
      result = cur;
    else if (flush)
      result = hazard_pkg::bubbleOp;
    else
      result = prev;
    stageNext = result;
  endfunction

  always_comb
  begin
    // D, E and M hold on stall before they look at flush
    nextD = stageNext(ctrl.stallD, ctrl.flushD, 1'b0, opD, opF);
    nextE = stageNext(ctrl.stallE, ctrl.flushE, 1'b0, opE, opD);
    nextM = stageNext(ctrl.stallM, ctrl.flushM, 1'b0, opM, opE);
    // W drops its instruction on flush even while stalled
    // a memory stall therefore kills writeback every cycle it lasts
    nextW = stageNext(ctrl.stallW, ctrl.flushW, 1'b1, opW, opM);
  end

  // Only state in the subsystem
  // Reset empties the pipe
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      opD <= hazard_pkg::bubbleOp;
      opE <= hazard_pkg::bubbleOp;
      opM <= hazard_pkg::bubbleOp;
      opW <= hazard_pkg::bubbleOp;
    end
    else
    begin
      opD <= nextD;
      opE <= nextE;
      opM <= nextM;
      opW <= nextW;
    end
  end

  // F has no tag register here
  // The fetch side holds opF itself while ctrl.stallF is set

endmodule

/* verilog/hazard.sv */
`timescale 1ns/1ns

module hazard
(
  // Register matches from regMatch
  input  hazard_pkg::matchT          match,
  // Destination qualifiers taken from the stage tags
  input  logic                       regWriteM,
  input  logic                       regWriteW,
  input  logic                       memToRegE,
  // Control flow strobes
  input  logic                       branchTakenE,
  input  logic                       pcWrPendingF,
  input  logic                       pcSrcW,
  // Exception handling
  input  hazard_pkg::exceptionFlushT exceptionFlush,
  input  logic                       exceptionStallD,
  // Cache misses
  input  logic                       dStall,
  input  logic                       iStall,
  // Coprocessor and micro-op sequencing
  input  logic                       coProcEn,
  input  logic                       uOpStallD,
  input  logic                       ldmStmForwardE,
  // CPSR moves
  input  logic                       regToCpsr,
  input  logic                       cpsrToReg,
  // Operand selects for the E stage muxes
  output hazard_pkg::forwardSelT     forwardAE,
  output hazard_pkg::forwardSelT     forwardBE,
  // Per-stage stall and flush levels
  output hazard_pkg::pipeCtrlT       ctrl,
  output logic                       incrementE,
  output logic                       stallUop
);

  // Load in E feeding an operand in D
  logic loadStallD;
  // Either cache stalling the whole pipe
  logic memStall;
  // Writes to the PC or CPSR that refetch from F
  logic ctrlRefetch;

  // Operand A select
  // M result wins over W since it is younger
  // LDM/STM address chaining always takes the M path
  always_comb
  begin
    if ((match.match1EM && regWriteM) || ldmStmForwardE)
      forwardAE = hazard_pkg::fwdMemory;
    else if (match.match1EW && regWriteW)
      forwardAE = hazard_pkg::fwdWriteback;
    else
      forwardAE = hazard_pkg::fwdRegFile;
  end

  // Operand B select, same priority without the LDM/STM term
  always_comb
  begin
    if (match.match2EM && regWriteM)
      forwardBE = hazard_pkg::fwdMemory;
    else if (match.match2EW && regWriteW)
      forwardBE = hazard_pkg::fwdWriteback;
    else
      forwardBE = hazard_pkg::fwdRegFile;
  end

  // Base register step for multiple transfers
  assign incrementE = ldmStmForwardE;

  // Load RAW, hold D until the load reaches M
  assign loadStallD = (match.match1DE || match.match2DE) && memToRegE;

  assign memStall    = dStall || iStall;
  assign ctrlRefetch = regToCpsr || cpsrToReg || coProcEn;

  // Micro-op sequencer halts on load-use and cache stalls only
  assign stallUop = loadStallD || memStall;

  // A stalling stage stalls everything behind it and flushes the next one
  always_comb
  begin
    // Fetch
    ctrl.stallF = loadStallD || pcWrPendingF || memStall || uOpStallD || ctrlRefetch;

    // Decode
    ctrl.stallD = loadStallD || memStall || uOpStallD || exceptionStallD;
    ctrl.flushD = pcWrPendingF || pcSrcW || branchTakenE || iStall ||
                  ctrlRefetch || exceptionFlush.flushD;

    // Execute, bubble behind a load stall or a taken branch
    ctrl.stallE = memStall;
    ctrl.flushE = loadStallD || branchTakenE || exceptionFlush.flushE;

    // Memory
    ctrl.stallM = memStall;
    ctrl.flushM = exceptionFlush.flushM;

    // Writeback is killed while memory is stalled
    ctrl.stallW = memStall;
    ctrl.flushW = memStall || exceptionFlush.flushW;
  end

endmodule

/* verilog/regMatch.sv */
`timescale 1ns/1ns

module regMatch
(
  // Tags of the decode, execute, memory and writeback stages
  input  hazard_pkg::stageOpT opD,
  input  hazard_pkg::stageOpT opE,
  input  hazard_pkg::stageOpT opM,
  input  hazard_pkg::stageOpT opW,
  // Raw match flags for the hazard unit
  output hazard_pkg::matchT   match
);

  // One comparator
  // Source side must be a live instruction actually reading the register
  // Destination side qualifiers (regWrite, memToReg) are checked in hazard
  function automatic logic srcMatch
  (
    input logic                stageValid,
    input logic                srcUsed,
    input hazard_pkg::regAddrT src,
    input hazard_pkg::regAddrT dest
  );
    srcMatch = stageValid && srcUsed && (src == dest);
  endfunction

  always_comb
  begin
    // Forwarding checks
    // E stage first operand against M and W results
    match.match1EM = srcMatch(opE.valid, opE.useA, opE.srcA, opM.dest);
    match.match1EW = srcMatch(opE.valid, opE.useA, opE.srcA, opW.dest);

    // E stage second operand against M and W results
    match.match2EM = srcMatch(opE.valid, opE.useB, opE.srcB, opM.dest);
    match.match2EW = srcMatch(opE.valid, opE.useB, opE.srcB, opW.dest);

    // Load-use checks
    // D stage operands against the instruction now in E
    // A load there cannot forward in time, so hazard stalls D
    match.match1DE = srcMatch(opD.valid, opD.useA, opD.srcA, opE.dest);
    match.match2DE = srcMatch(opD.valid, opD.useB, opD.srcB, opE.dest);
  end

  // Bubbles carry regWrite = 0 and memToReg = 0
  // so a match against a flushed destination is harmless downstream

endmodule

/* verilog/hazard_pkg.sv */
`include "hazard_settings.svh"

package hazard_pkg;

  // Register number as carried in the tags
  typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

  // Execute operand source select
  typedef logic [1:0] forwardSelT;

  // Operand source encodings
  localparam forwardSelT fwdRegFile   = 2'd0;
  localparam forwardSelT fwdWriteback = 2'd1;
  localparam forwardSelT fwdMemory    = 2'd2;

  // Register fields of one instruction as it moves down the pipe
  typedef struct packed {
    logic    valid;
    logic    useA;      // first source read
    logic    useB;      // second source read
    regAddrT srcA;
    regAddrT srcB;
    regAddrT dest;
    logic    regWrite;
    logic    memToReg;  // load result comes from memory
  } stageOpT;

  // Invalid tag loaded on reset and on flush
  localparam stageOpT bubbleOp = '0;

  // Cross-stage source/destination matches
  typedef struct packed {
    logic match1EM;
    logic match1EW;
    logic match2EM;
    logic match2EW;
    logic match1DE;
    logic match2DE;
  } matchT;

  // Per-stage flush strobes from the exception logic
  typedef struct packed {
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } exceptionFlushT;

  // Stall and flush levels for every stage
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } pipeCtrlT;

endpackage

/* include/hazard_settings.svh */
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// Register number width for an ARM-style register file
`define REG_ADDR_WIDTH 4

// Architectural registers visible to the pipeline
// R15 is the PC and is compared like any other register
`define REG_COUNT 16

`endif
